// File: Makefile
TOP = tb_csr_unit
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f csr_unit.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f csr_unit.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: csr_pkg.sv
`default_nettype none

package csr_pkg;

    // Core geometry
    localparam int NUM_LANES   = 4;
    localparam int NUM_THREADS = 8;
    localparam int NUM_WARPS   = 4;
    localparam int NW_BITS     = $clog2(NUM_WARPS);
    localparam int NT_BITS     = $clog2(NUM_THREADS);

    // Index of the lane group inside a warp
    localparam int PID_BITS    = $clog2(NUM_THREADS / NUM_LANES);

    // Destination register index and retire count widths
    localparam int NR_BITS     = 5;
    localparam int COMMIT_BITS = $clog2(NUM_LANES + 1);

    // Immediate field: CSR address below, zimm above it
    localparam int CSR_ADDR_BITS = 12;
    localparam int ZIMM_BITS     = 5;
    localparam int IMM_BITS      = CSR_ADDR_BITS + ZIMM_BITS;

    // CSR instruction opcodes
    localparam int OP_BITS = 2;
    localparam logic [OP_BITS-1:0] OP_CSRRW = 2'd0;
    localparam logic [OP_BITS-1:0] OP_CSRRS = 2'd1;
    localparam logic [OP_BITS-1:0] OP_CSRRC = 2'd2;

    // CSR address map
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ACC       = 12'h7C0;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MCYCLEH   = 12'hB80;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MINSTRETH = 12'hB82;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_THREAD_ID = 12'hCC0;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_WARP_ID   = 12'hCC1;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MHARTID   = 12'hF14;

endpackage

`default_nettype wire

// File: csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regfile (
    input  wire                                  clk,
    input  wire                                  rst_n,

    // Request in its issue cycle
    input  wire                                  req_valid,
    input  wire [csr_pkg::NW_BITS-1:0]           req_wid,
    input  wire [csr_pkg::OP_BITS-1:0]           req_op,
    input  wire [csr_pkg::CSR_ADDR_BITS-1:0]     csr_addr,
    input  wire [31:0]                           src_data,

    // Retired instruction count from commit
    input  wire                                  commit_valid,
    input  wire [csr_pkg::COMMIT_BITS-1:0]       commit_count,

    // Accelerator side
    input  wire [31:0]                           acc_read_in,
    output logic [31:0]                          acc_write_out,
    output logic                                 acc_write_en,

    // Value before the write
    output logic [31:0]                          old_data
);

    import csr_pkg::*;

    logic [31:0] mscratch;
    logic [31:0] warp_id [NUM_WARPS];
    logic [63:0] mcycle;
    logic [63:0] minstret;

    logic [31:0] new_data;
    logic        wr_en;
    logic        acc_wr;

    // Old value by address, zero for anything not held here
    always_comb begin
        case (csr_addr)
            CSR_MSCRATCH:  old_data = mscratch;
            CSR_WARP_ID:   old_data = warp_id[req_wid];
            CSR_ACC:       old_data = acc_read_in;
            CSR_MCYCLE:    old_data = mcycle[31:0];
            CSR_MCYCLEH:   old_data = mcycle[63:32];
            CSR_MINSTRET:  old_data = minstret[31:0];
            CSR_MINSTRETH: old_data = minstret[63:32];
            default:       old_data = '0;
        endcase
    end

    // Read-modify-write
    // Set and clear leave the register alone when the source is zero
    always_comb begin
        wr_en    = 1'b0;
        new_data = old_data;
        case (req_op)
            OP_CSRRW: begin
                wr_en    = req_valid;
                new_data = src_data;
            end
            OP_CSRRS: begin
                wr_en    = req_valid && (src_data != '0);
                new_data = old_data | src_data;
            end
            OP_CSRRC: begin
                wr_en    = req_valid && (src_data != '0);
                new_data = old_data & ~src_data;
            end
            default: begin
                wr_en    = 1'b0;
                new_data = old_data;
            end
        endcase
    end

    assign acc_wr = wr_en && (csr_addr == CSR_ACC);

    // Writable registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mscratch <= '0;
            for (int w = 0; w < NUM_WARPS; w++) begin
                warp_id[w] <= '0;
            end
        end else if (wr_en) begin
            if (csr_addr == CSR_MSCRATCH) begin
                mscratch <= new_data;
            end
            if (csr_addr == CSR_WARP_ID) begin
                warp_id[req_wid] <= new_data;
            end
        end
    end

    // Free-running cycle counter and retire counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + 64'd1;
            if (commit_valid) begin
                minstret <= minstret + 64'(commit_count);
            end
        end
    end

    // Accelerator write pulse lines up with the response strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_write_en <= 1'b0;
        end else begin
            acc_write_en <= acc_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_wr) begin
            acc_write_out <= new_data;
        end
    end

endmodule

`default_nettype wire

// File: csr_rsp_stage.sv
`timescale 1ns/1ps
`default_nettype none

module csr_rsp_stage (
    input  wire                                   clk,
    input  wire                                   rst_n,

    // Request fields in the issue cycle
    input  wire                                   req_valid,
    input  wire [csr_pkg::CSR_ADDR_BITS-1:0]      csr_addr,
    input  wire [csr_pkg::NW_BITS-1:0]            req_wid,
    input  wire [csr_pkg::NUM_LANES-1:0]          req_tmask,
    input  wire [csr_pkg::NR_BITS-1:0]            req_rd,
    input  wire                                   req_wb,

    // Read sources
    input  wire [31:0]                            old_data,
    input  wire [csr_pkg::NUM_LANES-1:0][31:0]    wtid,
    input  wire [csr_pkg::NUM_LANES-1:0][31:0]    gtid,

    // Response, one cycle after the request
    output logic                                  rsp_valid,
    output logic [csr_pkg::NW_BITS-1:0]           rsp_wid,
    output logic [csr_pkg::NUM_LANES-1:0]         rsp_tmask,
    output logic [csr_pkg::NR_BITS-1:0]           rsp_rd,
    output logic                                  rsp_wb,
    output logic [csr_pkg::NUM_LANES-1:0][31:0]   rsp_data
);

    import csr_pkg::*;

    logic [NUM_LANES-1:0][31:0] sel_data;

    // Thread and hart ids differ per lane, the rest is broadcast
    always_comb begin
        case (csr_addr)
            CSR_THREAD_ID: sel_data = wtid;
            CSR_MHARTID:   sel_data = gtid;
            default:       sel_data = {NUM_LANES{old_data}};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

    // Payload only matters while rsp_valid is high
    always_ff @(posedge clk) begin
        rsp_wid   <= req_wid;
        rsp_tmask <= req_tmask;
        rsp_rd    <= req_rd;
        rsp_wb    <= req_wb;
        rsp_data  <= sel_data;
    end

endmodule

`default_nettype wire

// File: csr_thread_ids.sv
`timescale 1ns/1ps
`default_nettype none

module csr_thread_ids #(
    parameter int CORE_ID = 0
) (
    input  wire [csr_pkg::PID_BITS-1:0]                 req_pid,
    input  wire [csr_pkg::NW_BITS-1:0]                  req_wid,

    // Thread index within the warp, per lane
    output logic [csr_pkg::NUM_LANES-1:0][31:0]         wtid,
    // Hart index within the core id space, per lane
    output logic [csr_pkg::NUM_LANES-1:0][31:0]         gtid
);

    import csr_pkg::*;

    logic [31:0] core_base;
    logic [31:0] warp_base;
    logic [31:0] group_base;

    // Core and warp offsets are shared by all lanes
    assign core_base  = 32'(CORE_ID) << (NW_BITS + NT_BITS);
    assign warp_base  = 32'(req_wid) << NT_BITS;
    assign group_base = 32'(req_pid) * 32'(NUM_LANES);

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            wtid[i] = group_base + 32'(i);
            gtid[i] = core_base + warp_base + wtid[i];
        end
    end

endmodule

`default_nettype wire

// File: csr_unit.f
csr_pkg.sv
csr_regfile.sv
csr_thread_ids.sv
csr_rsp_stage.sv
csr_unit.sv
tb_csr_unit.sv

// File: csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
    parameter int CORE_ID = 0
) (
    input  wire                                   clk,
    input  wire                                   rst_n,

    // Request strobe and fields
    input  wire                                   req_valid,
    input  wire [csr_pkg::NW_BITS-1:0]            req_wid,
    input  wire [csr_pkg::PID_BITS-1:0]           req_pid,
    input  wire [csr_pkg::NUM_LANES-1:0]          req_tmask,
    input  wire [csr_pkg::OP_BITS-1:0]            req_op,
    input  wire                                   req_use_imm,
    input  wire [csr_pkg::IMM_BITS-1:0]           req_imm,
    input  wire [31:0]                            req_rs1,
    input  wire [csr_pkg::NR_BITS-1:0]            req_rd,
    input  wire                                   req_wb,

    // Response strobe and fields
    output logic                                  rsp_valid,
    output logic [csr_pkg::NW_BITS-1:0]           rsp_wid,
    output logic [csr_pkg::NUM_LANES-1:0]         rsp_tmask,
    output logic [csr_pkg::NR_BITS-1:0]           rsp_rd,
    output logic                                  rsp_wb,
    output logic [csr_pkg::NUM_LANES-1:0][31:0]   rsp_data,

    // Commit
    input  wire                                   commit_valid,
    input  wire [csr_pkg::COMMIT_BITS-1:0]        commit_count,

    // Accelerator
    input  wire [31:0]                            acc_read_in,
    output logic [31:0]                           acc_write_out,
    output logic                                  acc_write_en
);

    import csr_pkg::*;

    logic [CSR_ADDR_BITS-1:0]   csr_addr;
    logic [ZIMM_BITS-1:0]       zimm;
    logic [31:0]                src_data;
    logic [31:0]                old_data;
    logic [NUM_LANES-1:0][31:0] wtid;
    logic [NUM_LANES-1:0][31:0] gtid;

    // Split the immediate into address and zimm
    assign csr_addr = req_imm[CSR_ADDR_BITS-1:0];
    assign zimm     = req_imm[CSR_ADDR_BITS +: ZIMM_BITS];

    // Source operand comes from lane 0 or the zero-extended zimm
    assign src_data = req_use_imm ? 32'(zimm) : req_rs1;

    csr_regfile regfile (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_wid       (req_wid),
        .req_op        (req_op),
        .csr_addr      (csr_addr),
        .src_data      (src_data),
        .commit_valid  (commit_valid),
        .commit_count  (commit_count),
        .acc_read_in   (acc_read_in),
        .acc_write_out (acc_write_out),
        .acc_write_en  (acc_write_en),
        .old_data      (old_data)
    );

    csr_thread_ids #(
        .CORE_ID (CORE_ID)
    ) thread_ids (
        .req_pid (req_pid),
        .req_wid (req_wid),
        .wtid    (wtid),
        .gtid    (gtid)
    );

    csr_rsp_stage rsp_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .csr_addr  (csr_addr),
        .req_wid   (req_wid),
        .req_tmask (req_tmask),
        .req_rd    (req_rd),
        .req_wb    (req_wb),
        .old_data  (old_data),
        .wtid      (wtid),
        .gtid      (gtid),
        .rsp_valid (rsp_valid),
        .rsp_wid   (rsp_wid),
        .rsp_tmask (rsp_tmask),
        .rsp_rd    (rsp_rd),
        .rsp_wb    (rsp_wb),
        .rsp_data  (rsp_data)
    );

endmodule

`default_nettype wire

// File: tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;

    import csr_pkg::*;

    localparam int CORE_ID    = 3;
    localparam int NUM_CYCLES = 2000;
    localparam int TIMEOUT    = 16;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       req_valid;
    logic [NW_BITS-1:0]         req_wid;
    logic [PID_BITS-1:0]        req_pid;
    logic [NUM_LANES-1:0]       req_tmask;
    logic [OP_BITS-1:0]         req_op;
    logic                       req_use_imm;
    logic [IMM_BITS-1:0]        req_imm;
    logic [31:0]                req_rs1;
    logic [NR_BITS-1:0]         req_rd;
    logic                       req_wb;
    logic                       rsp_valid;
    logic [NW_BITS-1:0]         rsp_wid;
    logic [NUM_LANES-1:0]       rsp_tmask;
    logic [NR_BITS-1:0]         rsp_rd;
    logic                       rsp_wb;
    logic [NUM_LANES-1:0][31:0] rsp_data;
    logic                       commit_valid;
    logic [COMMIT_BITS-1:0]     commit_count;
    logic [31:0]                acc_read_in;
    logic [31:0]                acc_write_out;
    logic                       acc_write_en;

    // Reference model state
    logic [31:0]                m_scratch;
    logic [31:0]                m_warp [NUM_WARPS];
    logic [63:0]                m_cycle;
    logic [63:0]                m_instret;
    logic                       last_commit_valid;
    logic [COMMIT_BITS-1:0]     last_commit_count;

    // Expected responses, oldest first
    logic                       q_valid [$];
    logic [NW_BITS-1:0]         q_wid [$];
    logic [NUM_LANES-1:0]       q_tmask [$];
    logic [NR_BITS-1:0]         q_rd [$];
    logic                       q_wb [$];
    logic [NUM_LANES-1:0][31:0] q_data [$];
    logic [CSR_ADDR_BITS-1:0]   q_addr [$];
    logic                       q_acc_en [$];
    logic [31:0]                q_acc_out [$];

    csr_unit #(
        .CORE_ID (CORE_ID)
    ) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_wid       (req_wid),
        .req_pid       (req_pid),
        .req_tmask     (req_tmask),
        .req_op        (req_op),
        .req_use_imm   (req_use_imm),
        .req_imm       (req_imm),
        .req_rs1       (req_rs1),
        .req_rd        (req_rd),
        .req_wb        (req_wb),
        .rsp_valid     (rsp_valid),
        .rsp_wid       (rsp_wid),
        .rsp_tmask     (rsp_tmask),
        .rsp_rd        (rsp_rd),
        .rsp_wb        (rsp_wb),
        .rsp_data      (rsp_data),
        .commit_valid  (commit_valid),
        .commit_count  (commit_count),
        .acc_read_in   (acc_read_in),
        .acc_write_out (acc_write_out),
        .acc_write_en  (acc_write_en)
    );

    always #4 clk = ~clk;

    task automatic stop_on_error();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    // Thread slot inside the warp for one lane
    function automatic logic [31:0] thread_index(input logic [PID_BITS-1:0] pid, input int lane);
        return 32'(int'(pid) * NUM_LANES + lane);
    endfunction

    // Harts are numbered core by core, then warp by warp
    function automatic logic [31:0] hart_index(input logic [NW_BITS-1:0] wid,
                                               input logic [PID_BITS-1:0] pid, input int lane);
        return 32'(CORE_ID * NUM_WARPS * NUM_THREADS + int'(wid) * NUM_THREADS)
               + thread_index(pid, lane);
    endfunction

    function automatic logic [31:0] model_read(input logic [CSR_ADDR_BITS-1:0] addr,
                                               input logic [NW_BITS-1:0] wid,
                                               input logic [31:0] acc_in);
        case (addr)
            CSR_MSCRATCH:  return m_scratch;
            CSR_WARP_ID:   return m_warp[wid];
            CSR_ACC:       return acc_in;
            CSR_MCYCLE:    return m_cycle[31:0];
            CSR_MCYCLEH:   return m_cycle[63:32];
            CSR_MINSTRET:  return m_instret[31:0];
            CSR_MINSTRETH: return m_instret[63:32];
            default:       return 32'd0;
        endcase
    endfunction

    // Storage CSRs come up more often so back-to-back updates happen
    function automatic logic [CSR_ADDR_BITS-1:0] pick_addr();
        case ($urandom % 14)
            0, 9, 10: return CSR_MSCRATCH;
            1, 11:    return CSR_WARP_ID;
            2:        return CSR_ACC;
            3:        return CSR_MCYCLE;
            4:        return CSR_MCYCLEH;
            5:        return CSR_MINSTRET;
            6:        return CSR_MINSTRETH;
            7:        return CSR_THREAD_ID;
            8:        return CSR_MHARTID;
            default:  return CSR_ADDR_BITS'($urandom);
        endcase
    endfunction

    task automatic push_expected(input logic valid, input logic [NW_BITS-1:0] wid,
                                 input logic [NUM_LANES-1:0] tmask,
                                 input logic [NR_BITS-1:0] rd, input logic wb,
                                 input logic [NUM_LANES-1:0][31:0] data,
                                 input logic [CSR_ADDR_BITS-1:0] addr,
                                 input logic acc_en, input logic [31:0] acc_out);
        q_valid.push_back(valid);
        q_wid.push_back(wid);
        q_tmask.push_back(tmask);
        q_rd.push_back(rd);
        q_wb.push_back(wb);
        q_data.push_back(data);
        q_addr.push_back(addr);
        q_acc_en.push_back(acc_en);
        q_acc_out.push_back(acc_out);
    endtask

    // Called right after a rising edge, drives one cycle of inputs
    task automatic issue(input logic valid, input logic [NW_BITS-1:0] wid,
                         input logic [PID_BITS-1:0] pid, input logic [NUM_LANES-1:0] tmask,
                         input logic [OP_BITS-1:0] op, input logic use_imm,
                         input logic [IMM_BITS-1:0] imm, input logic [31:0] rs1,
                         input logic [NR_BITS-1:0] rd, input logic wb,
                         input logic cm_valid, input logic [COMMIT_BITS-1:0] cm_count,
                         input logic [31:0] acc_in);
        logic [CSR_ADDR_BITS-1:0]   addr;
        logic [31:0]                src;
        logic [31:0]                old_val;
        logic [31:0]                new_val;
        logic                       do_write;
        logic                       acc_en;
        logic [NUM_LANES-1:0][31:0] data;
        // Counters as seen during this cycle
        m_cycle = m_cycle + 64'd1;
        if (last_commit_valid) begin
            m_instret = m_instret + 64'(last_commit_count);
        end
        last_commit_valid = cm_valid;
        last_commit_count = cm_count;

        addr    = imm[CSR_ADDR_BITS-1:0];
        src     = use_imm ? 32'(imm[IMM_BITS-1:CSR_ADDR_BITS]) : rs1;
        old_val = model_read(addr, wid, acc_in);
        case (op)
            OP_CSRRS: new_val = old_val | src;
            OP_CSRRC: new_val = old_val & ~src;
            default:  new_val = src;
        endcase
        do_write = valid && (op == OP_CSRRW || src != 32'd0);
        for (int i = 0; i < NUM_LANES; i++) begin
            if (addr == CSR_THREAD_ID) begin
                data[i] = thread_index(pid, i);
            end else if (addr == CSR_MHARTID) begin
                data[i] = hart_index(wid, pid, i);
            end else begin
                data[i] = old_val;
            end
        end

        acc_en = 1'b0;
        if (do_write) begin
            if (addr == CSR_MSCRATCH) begin
                m_scratch = new_val;
            end else if (addr == CSR_WARP_ID) begin
                m_warp[wid] = new_val;
            end else if (addr == CSR_ACC) begin
                acc_en = 1'b1;
            end
        end
        push_expected(valid, wid, tmask, rd, wb, data, addr, acc_en, new_val);

        req_valid    <= valid;
        req_wid      <= wid;
        req_pid      <= pid;
        req_tmask    <= tmask;
        req_op       <= op;
        req_use_imm  <= use_imm;
        req_imm      <= imm;
        req_rs1      <= rs1;
        req_rd       <= rd;
        req_wb       <= wb;
        commit_valid <= cm_valid;
        commit_count <= cm_count;
        acc_read_in  <= acc_in;
    endtask

    task automatic issue_idle();
        issue(1'b0, '0, '0, '0, OP_CSRRW, 1'b0, '0, 32'd0, '0, 1'b0, 1'b0, '0, 32'd0);
    endtask

    task automatic issue_random();
        logic [ZIMM_BITS-1:0] zimm;
        logic [31:0]          rs1;
        zimm = (($urandom % 3) == 0) ? '0 : ZIMM_BITS'($urandom);
        rs1  = (($urandom % 3) == 0) ? 32'd0 : $urandom;
        issue(($urandom % 4) != 0, NW_BITS'($urandom), PID_BITS'($urandom),
              NUM_LANES'($urandom), OP_BITS'($urandom % 3), 1'($urandom),
              {zimm, pick_addr()}, rs1, NR_BITS'($urandom), 1'($urandom),
              1'($urandom), COMMIT_BITS'($urandom % (NUM_LANES + 1)), $urandom);
    endtask

    // Called after a falling edge, outputs are settled here
    task automatic check_response();
        logic                       exp_valid;
        logic [NW_BITS-1:0]         exp_wid;
        logic [NUM_LANES-1:0]       exp_tmask;
        logic [NR_BITS-1:0]         exp_rd;
        logic                       exp_wb;
        logic [NUM_LANES-1:0][31:0] exp_data;
        logic [CSR_ADDR_BITS-1:0]   exp_addr;
        logic                       exp_acc_en;
        logic [31:0]                exp_acc_out;
        if (q_valid.size() == 0) begin
            $display("no expected response is left to compare against");
            stop_on_error();
        end
        exp_valid   = q_valid.pop_front();
        exp_wid     = q_wid.pop_front();
        exp_tmask   = q_tmask.pop_front();
        exp_rd      = q_rd.pop_front();
        exp_wb      = q_wb.pop_front();
        exp_data    = q_data.pop_front();
        exp_addr    = q_addr.pop_front();
        exp_acc_en  = q_acc_en.pop_front();
        exp_acc_out = q_acc_out.pop_front();
        check_value("rsp_valid", 32'(exp_valid), 32'(rsp_valid));
        check_value("acc_write_en", 32'(exp_acc_en), 32'(acc_write_en));
        if (exp_valid) begin
            check_value("rsp_wid", 32'(exp_wid), 32'(rsp_wid));
            check_value("rsp_tmask", 32'(exp_tmask), 32'(rsp_tmask));
            check_value("rsp_rd", 32'(exp_rd), 32'(rsp_rd));
            check_value("rsp_wb", 32'(exp_wb), 32'(rsp_wb));
            for (int i = 0; i < NUM_LANES; i++) begin
                check_value($sformatf("rsp_data[%0d] csr %03h", i, exp_addr),
                            exp_data[i], rsp_data[i]);
            end
        end
        if (exp_acc_en) begin
            check_value("acc_write_out", exp_acc_out, acc_write_out);
        end
    endtask

    // Single read of mscratch, counting cycles until its response shows up
    task automatic measure_latency();
        int   cycles;
        logic seen;
        @(posedge clk);
        issue(1'b1, '0, '0, '1, OP_CSRRS, 1'b1, {ZIMM_BITS'(0), CSR_MSCRATCH}, 32'd0,
              NR_BITS'(1), 1'b1, 1'b0, '0, 32'd0);
        @(negedge clk);
        check_response();
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            if (cycles >= TIMEOUT) begin
                $display("timeout: no response to the mscratch read after %0d cycles", cycles);
                stop_on_error();
            end
            @(posedge clk);
            issue_idle();
            cycles++;
            @(negedge clk);
            seen = rsp_valid;
        end
        check_value("response latency", 32'd1, 32'(cycles));
        check_response();
    endtask

    initial begin
        void'($urandom(42));
        rst_n        <= 1'b0;
        req_valid    <= 1'b0;
        req_wid      <= '0;
        req_pid      <= '0;
        req_tmask    <= '0;
        req_op       <= OP_CSRRW;
        req_use_imm  <= 1'b0;
        req_imm      <= '0;
        req_rs1      <= 32'd0;
        req_rd       <= '0;
        req_wb       <= 1'b0;
        commit_valid <= 1'b0;
        commit_count <= '0;
        acc_read_in  <= 32'd0;
        m_scratch = 32'd0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            m_warp[w] = 32'd0;
        end

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // First cycle out of reset carries no request and mcycle reads 0 here
        m_cycle           = 64'd0;
        m_instret         = 64'd0;
        last_commit_valid = 1'b0;
        last_commit_count = '0;
        push_expected(1'b0, '0, '0, '0, 1'b0, '0, '0, 1'b0, 32'd0);

        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clk);
            issue_random();
            @(negedge clk);
            check_response();
        end
        measure_latency();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
